//--- Makefile
# Verilator build and run of the vicii_timing testbench

VERILATOR ?= verilator
TOP       ?= tb_vicii_timing
FILELIST  ?= vicii_timing.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- beam_if.sv
`timescale 1ns/1ps
`default_nettype none

// beam position as seen by everything downstream of the raster counter
interface beam_if import vic_pkg::*; ();

   // current pixel within the line
   raster_x_t    raster_x;
   // current line within the frame
   raster_line_t raster_line;
   // one tick pulse when raster_x has just wrapped to 0
   logic         line_start;
   // one tick pulse when raster_line has just wrapped to 0
   logic         frame_start;

   // raster counter side
   modport source (output raster_x, output raster_line,
                   output line_start, output frame_start);

   // register block side
   modport sink (input raster_x, input raster_line,
                 input line_start, input frame_start);

endinterface : beam_if

`default_nettype wire

//--- tb_vicii_timing.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vicii_timing import vic_pkg::*; ();

   localparam int PHASES = 3;
   // longest frame in dot4x ticks for 520 x 263 pixels
   localparam longint MAX_FRAME = 64'd520 * 64'd263 * 64'd4;
   localparam longint WATCHDOG_NS = 64'd2 * 64'(PHASES) * (MAX_FRAME + 64'd20000)
                                    * 64'd10;

   logic clk_dot4x = 1'b0;
   logic rst = 1'b1;
   chip_type chip = CHIP6569;
   logic ce = 1'b1;
   logic rw = 1'b1;
   logic [5:0] adi = '0;
   logic [7:0] dbi = '0;
   logic [7:0] dbo;
   logic irq;
   logic csync;
   logic clk_phi;
   logic clk_dot;

   // values applied at the next drive point
   logic d_rst = 1'b1;
   chip_type d_chip = CHIP6569;
   logic [31:0] lfsr = 32'h5d79_9cde;

   // model state with m_k as the tick since reset released
   int m_k, m_xmax, m_ymax, m_hs, m_he, m_vb;
   logic [6:0] m_ctrl1, m_ctrl1_d;
   raster_line_t m_cmp, m_rd_line;
   logic m_erst, m_irst, m_irq, m_csync, m_wrote;
   logic [7:0] m_dbo;

   vicii_timing u_vicii_timing (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip      (chip),
      .ce        (ce),
      .rw        (rw),
      .adi       (adi),
      .dbi       (dbi),
      .dbo       (dbo),
      .irq       (irq),
      .csync     (csync),
      .clk_phi   (clk_phi),
      .clk_dot   (clk_dot)
   );

   always #5 clk_dot4x = ~clk_dot4x;

   initial begin
      #(WATCHDOG_NS);
      $display("simulation timed out before all tests finished");
      $display("TESTS FAILED");
      $fatal(1);
   end

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // line and frame sizes per chip variant
   task automatic set_limits(input chip_type c);
      case (c)
         CHIP6567R8: begin
            m_xmax = 519;
            m_ymax = 262;
            m_hs = 409;
            m_he = 446;
            m_vb = 14;
         end
         CHIP6567R56A: begin
            m_xmax = 511;
            m_ymax = 261;
            m_hs = 409;
            m_he = 446;
            m_vb = 14;
         end
         default: begin
            m_xmax = 503;
            m_ymax = 311;
            m_hs = 408;
            m_he = 444;
            m_vb = 301;
         end
      endcase
   endtask

   // one pixel per four ticks with position 0 before the first edge
   function automatic int x_at(input int k);
      return (k < 0) ? 0 : (k / 4) % (m_xmax + 1);
   endfunction

   function automatic int line_at(input int k);
      return (k < 0) ? 0 : ((k / 4) / (m_xmax + 1)) % (m_ymax + 1);
   endfunction

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAILED %s expected %h got %h", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("FAILED %s expected %h got %h", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_line(input string name, input raster_line_t exp,
                             input raster_line_t act);
      if (act !== exp) begin
         $display("FAILED %s expected %h got %h", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1);
      end
   endtask

   // advance the model over one edge using the inputs seen before it
   task automatic model_edge();
      int kp;
      int x;
      int ln;
      logic wr, phs, ls, hs, vs;
      logic [7:0] rd;
      kp = m_k;
      m_k = m_k + 1;
      x = x_at(kp);
      ln = line_at(kp);
      wr = (m_k >= 1) && (m_k % 32 == 0) && !ce && !rw;
      phs = (m_k >= 1) && ((m_k - 1) % 32 == 0);
      ls = (kp >= 4) && (kp % 4 == 0) && (x == 0);
      case (adi)
         6'h11: rd = {ln[8], m_ctrl1_d};
         6'h12: rd = ln[7:0];
         6'h19: rd = {m_irq, 6'b111111, m_irst};
         6'h1A: rd = {7'b1111111, m_erst};
         default: rd = 8'hFF;
      endcase
      m_dbo = (!ce && rw) ? rd : 8'hFF;
      m_rd_line = raster_line_t'(ln);
      m_irq = m_irst && m_erst;
      if (ls && raster_line_t'(ln) == m_cmp)
         m_irst = 1'b1;
      else if (wr && adi == 6'h19 && dbi[0])
         m_irst = 1'b0;
      if (phs)
         m_ctrl1_d = m_ctrl1;
      m_wrote = wr;
      if (wr) begin
         case (adi)
            6'h11: begin
               m_ctrl1 = dbi[6:0];
               m_cmp[8] = dbi[7];
            end
            6'h12: m_cmp[7:0] = dbi;
            6'h1A: m_erst = dbi[0];
            default: ;
         endcase
      end
      // composite sync inverted on the vsync lines
      hs = (x >= m_hs) && (x < m_he);
      vs = (ln >= m_vb) && (ln < m_vb + VSYNC_LINES);
      m_csync = vs ? hs : ~hs;
   endtask

   // model update on the edge then drive and check at the falling edge
   task automatic cycle(input logic n_ce, input logic n_rw, input logic [5:0] n_adi,
                        input logic [7:0] n_dbi);
      @(posedge clk_dot4x);
      if (rst) begin
         m_k = -1;
         m_ctrl1 = '0;
         m_ctrl1_d = '0;
         m_cmp = '0;
         m_erst = 1'b0;
         m_irst = 1'b0;
         m_irq = 1'b0;
         m_dbo = 8'hFF;
         m_csync = 1'b1;
         m_wrote = 1'b0;
         set_limits(chip);
      end else begin
         model_edge();
      end
      #1;
      rst = d_rst;
      chip = d_chip;
      ce = n_ce;
      rw = n_rw;
      adi = n_adi;
      dbi = n_dbi;
      @(negedge clk_dot4x);
      check_bit("clk_phi", (m_k >= 0) && (m_k % 32 >= 16), clk_phi);
      check_bit("clk_dot", (m_k >= 0) && (m_k % 4 >= 2), clk_dot);
      check_bit("csync", m_csync, csync);
      check_bit("irq", m_irq, irq);
      check_byte("dbo", m_dbo, dbo);
   endtask

   task automatic idle(input int n);
      repeat (n) cycle(1'b1, 1'b1, '0, '0);
   endtask

   // hold the write on the bus until the commit edge has passed
   task automatic bus_write(input logic [5:0] a, input logic [7:0] d);
      int tries;
      tries = 0;
      do begin
         cycle(1'b0, 1'b0, a, d);
         tries++;
      end while (!m_wrote && tries < 40);
      if (!m_wrote) begin
         $display("a bus write never reached a commit tick");
         $display("TESTS FAILED");
         $fatal(1);
      end
      idle(1);
   endtask

   // line msb from ctrl1 and low bits from raster in back to back reads
   task automatic read_line();
      raster_line_t exp_l, act_l;
      cycle(1'b0, 1'b1, 6'h11, '0);
      cycle(1'b0, 1'b1, 6'h12, '0);
      exp_l[8] = m_rd_line[8];
      act_l[8] = dbo[7];
      cycle(1'b1, 1'b1, '0, '0);
      exp_l[7:0] = m_rd_line[7:0];
      act_l[7:0] = dbo;
      check_line("raster_line", exp_l, act_l);
   endtask

   task automatic run_phase(input chip_type c);
      int frame;
      int sel;
      logic seen_irq;
      raster_line_t cmp;
      logic [5:0] a;
      d_chip = c;
      d_rst = 1'b1;
      idle(5);
      d_rst = 1'b0;
      idle(3);
      // register write and read back
      repeat (6) begin
         bus_write(6'h11, 8'(rand_bits(8)));
         idle(2);
         cycle(1'b0, 1'b1, 6'h11, '0);
         bus_write(6'h1A, 8'(rand_bits(8)));
         cycle(1'b0, 1'b1, 6'h1A, '0);
         a = 6'(rand_bits(6));
         if (a != 6'h11 && a != 6'h12 && a != 6'h19 && a != 6'h1A)
            cycle(1'b0, 1'b1, a, '0);
         cycle(1'b1, 1'(rand_bits(1)), 6'(rand_bits(6)), '0);
         idle(1);
      end
      // raster compare with the interrupt enabled
      cmp = raster_line_t'(rand_bits(9) % (m_ymax + 1));
      bus_write(6'h12, cmp[7:0]);
      bus_write(6'h11, {cmp[8], 7'(rand_bits(7))});
      bus_write(6'h1A, 8'h01);
      bus_write(6'h19, 8'h01);
      seen_irq = 1'b0;
      frame = (m_xmax + 1) * (m_ymax + 1) * 4;
      for (int i = 0; i < frame; i++) begin
         if (i % 4096 == 100) begin
            read_line();
            i += 2;
         end else begin
            sel = rand_bits(2);
            a = (i % 16 == 0) ? 6'(rand_bits(6)) :
                (sel == 0) ? 6'h11 : (sel == 1) ? 6'h12 : (sel == 2) ? 6'h19 : 6'h1A;
            cycle(1'(rand_bits(1)), 1'b1, a, '0);
         end
         if (irq)
            seen_irq = 1'b1;
      end
      if (!seen_irq) begin
         $display("irq never rose during a full frame");
         $display("TESTS FAILED");
         $fatal(1);
      end
      bus_write(6'h19, 8'h01);
      idle(3);
      // latch still visible with the enable clear
      bus_write(6'h1A, 8'h00);
      cmp = raster_line_t'((line_at(m_k) + 2) % (m_ymax + 1));
      bus_write(6'h12, cmp[7:0]);
      bus_write(6'h11, {cmp[8], m_ctrl1});
      repeat (3 * (m_xmax + 1) * 4) cycle(1'b0, 1'b1, 6'h19, '0);
      check_bit("irst", 1'b1, dbo[0]);
   endtask

   initial begin
      chip_type c;
      chip_type prev;
      c = chip_type'(2'(rand_bits(2)));
      for (int p = 0; p < PHASES; p++) begin
         run_phase(c);
         prev = c;
         while (c == prev)
            c = chip_type'(2'(rand_bits(2)));
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule : tb_vicii_timing

`default_nettype wire

//--- vic_clocks.sv
`timescale 1ns/1ps
`default_nettype none

module vic_clocks import vic_pkg::*; (
   input  logic clk_dot4x,
   input  logic rst,
   output logic clk_phi,
   output logic clk_dot,
   output logic pixel_tick,
   output logic commit_tick,
   output logic phi_start_tick
);

   // tick within the current phi cycle
   logic [4:0] tick;
   logic [4:0] tick_next;
   // position inside the current pixel
   logic [1:0] dot_phase;

   // wrap at the end of the phi cycle
   assign tick_next = (tick == 5'(TICKS_PER_PHI - 1)) ? 5'd0 : tick + 5'd1;
   assign dot_phase = 2'(tick_next % TICKS_PER_DOT);

   // parked on the last tick so the first edge out of reset lands on tick 0
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         tick           <= 5'(TICKS_PER_PHI - 1);
         clk_phi        <= 1'b0;
         clk_dot        <= 1'b0;
         pixel_tick     <= 1'b0;
         commit_tick    <= 1'b0;
         phi_start_tick <= 1'b0;
      end else begin
         tick           <= tick_next;
         // phi low for the first half, high for the second
         clk_phi        <= (tick_next >= 5'(TICKS_PER_PHI / 2));
         // dot high on the second half of each pixel
         clk_dot        <= (dot_phase >= 2'(TICKS_PER_DOT / 2));
         // last tick of a pixel, raster counter steps on its closing edge
         pixel_tick     <= (dot_phase == 2'(TICKS_PER_DOT - 1));
         commit_tick    <= (tick_next == 5'(REG_COMMIT_TICK));
         phi_start_tick <= (tick_next == 5'd0);
      end
   end

   // phi edges only at the half cycle boundaries
   a_phi_edges : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      $changed(clk_phi) |-> (tick == 5'd0 || tick == 5'(TICKS_PER_PHI / 2))
   );

endmodule : vic_clocks

`default_nettype wire

//--- vic_pkg.sv
`default_nettype none

package vic_pkg;

   // chip variants, same encoding as the chip select straps
   typedef enum logic [1:0] {
      CHIP6567R8   = 2'd0,
      CHIP6567R56A = 2'd1,
      CHIP6569     = 2'd2,
      CHIPUNUSED   = 2'd3
   } chip_type;

   // register offsets still decoded by the timing core
   typedef enum logic [5:0] {
      REG_CTRL1  = 6'h11,
      REG_RASTER = 6'h12,
      REG_IRQ    = 6'h19,
      REG_IRQ_EN = 6'h1A
   } reg_addr_t;

   // beam position types
   typedef logic [9:0] raster_x_t;
   typedef logic [8:0] raster_line_t;

   // per chip line length, frame height and sync window
   typedef struct packed {
      raster_x_t    raster_x_max;
      raster_line_t raster_y_max;
      raster_x_t    hsync_start;
      raster_x_t    hsync_end;
      raster_line_t vblank_start;
   } chip_limits_t;

   // dot4x ticks in one phi cycle
   localparam int TICKS_PER_PHI = 32;
   // dot4x ticks in one pixel
   localparam int TICKS_PER_DOT = 4;
   // last tick of the phi high half, cpu writes land here
   localparam int REG_COMMIT_TICK = 31;
   // lines of inverted sync from vblank_start on
   localparam int VSYNC_LINES = 3;

   function automatic chip_limits_t chip_limits(input chip_type chip);
      chip_limits_t lim;
      case (chip)
         CHIP6567R8: begin
            // 520 pixels, 263 lines
            lim.raster_x_max = 10'd519;
            lim.raster_y_max = 9'd262;
            lim.hsync_start  = 10'd409;
            lim.hsync_end    = 10'd446;
            lim.vblank_start = 9'd14;
         end
         CHIP6567R56A: begin
            // 512 pixels, 262 lines
            lim.raster_x_max = 10'd511;
            lim.raster_y_max = 9'd261;
            lim.hsync_start  = 10'd409;
            lim.hsync_end    = 10'd446;
            lim.vblank_start = 9'd14;
         end
         default: begin
            // 6569 pal, also taken for the unused strap setting
            lim.raster_x_max = 10'd503;
            lim.raster_y_max = 9'd311;
            lim.hsync_start  = 10'd408;
            lim.hsync_end    = 10'd444;
            lim.vblank_start = 9'd301;
         end
      endcase
      return lim;
   endfunction

endpackage : vic_pkg

`default_nettype wire

//--- vic_raster.sv
`timescale 1ns/1ps
`default_nettype none

module vic_raster import vic_pkg::*; (
   input  logic     clk_dot4x,
   input  logic     rst,
   input  chip_type chip,
   input  logic     pixel_tick,
   beam_if.source   beam,
   output logic     csync
);

   // limits for the strapped chip, chip only moves under reset
   chip_limits_t lim;
   // end of line and end of frame on the current position
   logic         last_x;
   logic         last_line;
   // sync windows for the current position
   logic         hsync_zone;
   logic         vsync_zone;
   raster_line_t vsync_end;

   assign lim = chip_limits(chip);

   assign last_x    = (beam.raster_x == lim.raster_x_max);
   assign last_line = (beam.raster_line == lim.raster_y_max);

   // position counters
   // both move on the edge that closes the pixel_tick tick
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         beam.raster_x    <= '0;
         beam.raster_line <= '0;
         beam.line_start  <= 1'b0;
         beam.frame_start <= 1'b0;
      end else begin
         // pulses last a single tick
         beam.line_start  <= 1'b0;
         beam.frame_start <= 1'b0;
         if (pixel_tick) begin
            if (last_x) begin
               beam.raster_x   <= '0;
               beam.line_start <= 1'b1;
               if (last_line) begin
                  beam.raster_line <= '0;
                  beam.frame_start <= 1'b1;
               end else begin
                  beam.raster_line <= beam.raster_line + 9'd1;
               end
            end else begin
               beam.raster_x <= beam.raster_x + 10'd1;
            end
         end
      end
   end

   // hsync window is half open, end pixel is already outside
   assign hsync_zone = (beam.raster_x >= lim.hsync_start) &&
                       (beam.raster_x < lim.hsync_end);

   // vsync spans a few lines from vblank_start
   // no chip puts these lines across the frame wrap
   assign vsync_end  = lim.vblank_start + raster_line_t'(VSYNC_LINES);
   assign vsync_zone = (beam.raster_line >= lim.vblank_start) &&
                       (beam.raster_line < vsync_end);

   // composite sync, active low
   // during vsync the pulse is inverted, serration style
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         csync <= 1'b1;
      end else if (vsync_zone) begin
         csync <= hsync_zone;
      end else begin
         csync <= ~hsync_zone;
      end
   end

   // x counter stays inside the line for the selected chip
   a_x_in_range : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      beam.raster_x <= lim.raster_x_max
   );

   // line counter stays inside the frame
   a_line_in_range : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      beam.raster_line <= lim.raster_y_max
   );

endmodule : vic_raster

`default_nettype wire

//--- vic_registers.sv
`timescale 1ns/1ps
`default_nettype none

module vic_registers import vic_pkg::*; (
   input  logic       clk_dot4x,
   input  logic       rst,
   input  logic       commit_tick,
   input  logic       phi_start_tick,
   beam_if.sink       beam,
   input  logic       ce,
   input  logic       rw,
   input  logic [5:0] adi,
   input  logic [7:0] dbi,
   output logic [7:0] dbo,
   output logic       irq
);

   // control bits 6:0 of $d011
   // bit 7 lives in the compare value
   logic [6:0]   ctrl1;
   // copy taken at phi start as seen by reads
   logic [6:0]   ctrl1_d;
   // raster compare line
   raster_line_t raster_cmp;
   // raster interrupt latch and its enable
   logic         irst;
   logic         erst;
   // decoded address and write strobe
   reg_addr_t    addr;
   logic         wr_commit;
   // raster match on the first tick of a line
   logic         rst_match;
   // cpu asks to clear the raster latch
   logic         irst_clr;
   // read data for the current address
   logic [7:0]   rd_data;

   assign addr = reg_addr_t'(adi);

   // writes only land on the closing edge of the commit tick
   assign wr_commit = commit_tick && !ce && !rw;

   assign irst_clr = wr_commit && (addr == REG_IRQ) && dbi[0];

   // line_start marks the tick where raster_line has just moved
   assign rst_match = beam.line_start && (beam.raster_line == raster_cmp);

   // register writes
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ctrl1      <= '0;
         raster_cmp <= '0;
         erst       <= 1'b0;
      end else if (wr_commit) begin
         case (addr)
            REG_CTRL1: begin
               ctrl1         <= dbi[6:0];
               // bit 7 is compare bit 8
               raster_cmp[8] <= dbi[7];
            end
            REG_RASTER: raster_cmp[7:0] <= dbi;
            REG_IRQ_EN: erst <= dbi[0];
            // irq latch clears are handled with the latch
            default: ;
         endcase
      end
   end

   // delayed control refreshed once per phi cycle
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ctrl1_d <= '0;
      end else if (phi_start_tick) begin
         ctrl1_d <= ctrl1;
      end
   end

   // raster interrupt latch
   // a new match wins over a clear on the same edge
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst <= 1'b0;
      end else if (rst_match) begin
         irst <= 1'b1;
      end else if (irst_clr) begin
         irst <= 1'b0;
      end
   end

   // irq pin is active high and one tick behind latch and enable
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irq <= 1'b0;
      end else begin
         irq <= irst && erst;
      end
   end

   // read mux
   always_comb begin
      case (addr)
         // bit 7 reads back the live line msb
         REG_CTRL1:  rd_data = {beam.raster_line[8], ctrl1_d};
         REG_RASTER: rd_data = beam.raster_line[7:0];
         REG_IRQ:    rd_data = {irq, 6'b111111, irst};
         REG_IRQ_EN: rd_data = {7'b1111111, erst};
         default:    rd_data = 8'hFF;
      endcase
   end

   // read data registered every tick
   // idle bus reads ff
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         dbo <= 8'hFF;
      end else if (!ce && rw) begin
         dbo <= rd_data;
      end else begin
         dbo <= 8'hFF;
      end
   end

   // line_start only comes with the first pixel of a line
   a_line_start_at_x0 : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      beam.line_start |-> (beam.raster_x == '0)
   );

   // frame wrap always comes with a line wrap onto line 0
   a_frame_on_line : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      beam.frame_start |-> (beam.line_start && beam.raster_line == '0)
   );

endmodule : vic_registers

`default_nettype wire

//--- vicii_timing.f
vic_pkg.sv
beam_if.sv
vic_clocks.sv
vic_raster.sv
vic_registers.sv
vicii_timing.sv
tb_vicii_timing.sv

//--- vicii_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vicii_timing import vic_pkg::*; (
   input  logic       clk_dot4x,
   input  logic       rst,
   input  chip_type   chip,
   input  logic       ce,
   input  logic       rw,
   input  logic [5:0] adi,
   input  logic [7:0] dbi,
   output logic [7:0] dbo,
   output logic       irq,
   output logic       csync,
   output logic       clk_phi,
   output logic       clk_dot
);

   // strobes from the phase ring
   logic pixel_tick;
   logic commit_tick;
   logic phi_start_tick;

   // beam position shared by raster counter and registers
   beam_if beam ();

   // phi, dot and per tick strobes
   vic_clocks u_clocks (
      .clk_dot4x      (clk_dot4x),
      .rst            (rst),
      .clk_phi        (clk_phi),
      .clk_dot        (clk_dot),
      .pixel_tick     (pixel_tick),
      .commit_tick    (commit_tick),
      .phi_start_tick (phi_start_tick)
   );

   // raster position and composite sync
   vic_raster u_raster (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .chip       (chip),
      .pixel_tick (pixel_tick),
      .beam       (beam.source),
      .csync      (csync)
   );

   // cpu register window and raster irq
   vic_registers u_registers (
      .clk_dot4x      (clk_dot4x),
      .rst            (rst),
      .commit_tick    (commit_tick),
      .phi_start_tick (phi_start_tick),
      .beam           (beam.sink),
      .ce             (ce),
      .rw             (rw),
      .adi            (adi),
      .dbi            (dbi),
      .dbo            (dbo),
      .irq            (irq)
   );

endmodule : vicii_timing

`default_nettype wire
